// ==== verilog/switch_pkg.sv ====
package switch_pkg;

    localparam int NUM_PORTS     = 4;
    localparam int MIN_FRAME_LEN = 64;
    localparam int MAX_FRAME_LEN = 1518;
    // port buffers and the shared output data queue
    localparam int BUF_DEPTH     = 2048;
    localparam int DESC_DEPTH    = 16;

    typedef logic [7:0]  byte_t;
    typedef logic [1:0]  port_id_t;
    typedef logic [10:0] frame_len_t;
    typedef logic [10:0] buf_addr_t;

    // one GMII receive beat
    typedef struct packed {
        logic  dv;
        logic  er;
        byte_t data;
    } gmii_rx_t;

    // queued per frame, ahead of its bytes
    typedef struct packed {
        port_id_t   port;
        frame_len_t len;
    } frame_desc_t;

    typedef enum logic [1:0] {
        MUX_IDLE,
        MUX_DESC,
        MUX_COPY
    } mux_state_t;

endpackage

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_wr,
    input  logic [WIDTH-1:0]       i_din,
    input  logic                   i_rd,
    output logic [WIDTH-1:0]       o_dout,
    output logic                   o_empty,
    output logic                   o_full,
    output logic [$clog2(DEPTH):0] o_count
);

    logic [WIDTH-1:0]         mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (i_wr) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (i_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_wr, i_rd})
                2'b10:   o_count <= o_count + 1'b1;
                2'b01:   o_count <= o_count - 1'b1;
                default: o_count <= o_count;
            endcase
        end
    end

    // head entry shows without a read
    assign o_dout  = mem[rd_ptr];
    assign o_empty = (o_count == '0);
    assign o_full  = (int'(o_count) == DEPTH);

    assert property (@(posedge clk) disable iff (!i_arst_n) !(i_wr && o_full))
        else $error("sync_fifo: write while full");

    assert property (@(posedge clk) disable iff (!i_arst_n) !(i_rd && o_empty))
        else $error("sync_fifo: read while empty");

endmodule

// ==== verilog/port_rx.sv ====
`timescale 1ns/1ps

module port_rx #(
    parameter switch_pkg::port_id_t PORT_ID = '0
) (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  switch_pkg::gmii_rx_t    i_rx,
    input  logic                    i_desc_rd,
    input  logic                    i_data_rd,
    output logic                    o_desc_empty,
    output switch_pkg::frame_desc_t o_desc,
    output switch_pkg::byte_t       o_data
);

    import switch_pkg::*;

    byte_t                      buf_mem [BUF_DEPTH];
    buf_addr_t                  wr_ptr;
    buf_addr_t                  commit_ptr;
    buf_addr_t                  rd_ptr;
    logic [$bits(buf_addr_t):0] used;
    frame_len_t                 len_cnt;
    logic                       in_frame;
    logic                       err_seen;
    logic                       overrun;
    logic                       room_ok;
    logic                       byte_wr;
    logic                       eof;
    logic                       frame_ok;
    logic                       commit;
    logic                       desc_full;
    logic                       desc_push;
    frame_desc_t                desc_q;

    // committed bytes plus the frame so far must leave room for one more
    assign room_ok  = (int'(used) + int'(len_cnt)) < BUF_DEPTH;
    assign byte_wr  = i_rx.dv && !overrun && room_ok && (int'(len_cnt) < MAX_FRAME_LEN);
    assign eof      = in_frame && !i_rx.dv;
    assign frame_ok = !err_seen && !overrun && !desc_full
                      && (int'(len_cnt) >= MIN_FRAME_LEN)
                      && (int'(len_cnt) <= MAX_FRAME_LEN);
    assign commit   = eof && frame_ok;

    always_ff @(posedge clk) begin
        if (byte_wr) begin
            buf_mem[wr_ptr] <= i_rx.data;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            in_frame   <= 1'b0;
            len_cnt    <= '0;
            err_seen   <= 1'b0;
            overrun    <= 1'b0;
            wr_ptr     <= '0;
            commit_ptr <= '0;
            desc_push  <= 1'b0;
        end else begin
            in_frame  <= i_rx.dv;
            desc_push <= commit;
            if (i_rx.dv) begin
                // saturate so an oversize frame never looks short
                if (len_cnt != '1) begin
                    len_cnt <= len_cnt + 1'b1;
                end
                if (i_rx.er) begin
                    err_seen <= 1'b1;
                end
                if (byte_wr) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end else if (!room_ok) begin
                    overrun <= 1'b1;
                end
            end else if (eof) begin
                len_cnt  <= '0;
                err_seen <= 1'b0;
                overrun  <= 1'b0;
                if (frame_ok) begin
                    commit_ptr <= wr_ptr;
                end else begin
                    wr_ptr <= commit_ptr;
                end
            end
        end
    end

    // descriptor is pushed one cycle after the decision
    always_ff @(posedge clk) begin
        if (commit) begin
            desc_q.port <= PORT_ID;
            desc_q.len  <= len_cnt;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (i_data_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (commit && i_data_rd) begin
                used <= used + {1'b0, len_cnt} - 1'b1;
            end else if (commit) begin
                used <= used + {1'b0, len_cnt};
            end else if (i_data_rd) begin
                used <= used - 1'b1;
            end
        end
    end

    assign o_data = buf_mem[rd_ptr];

    sync_fifo #(
        .WIDTH ($bits(frame_desc_t)),
        .DEPTH (DESC_DEPTH)
    ) u_desc_fifo (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_wr     (desc_push),
        .i_din    (desc_q),
        .i_rd     (i_desc_rd),
        .o_dout   (o_desc),
        .o_empty  (o_desc_empty),
        .o_full   (desc_full),
        .o_count  ()
    );

    // reader stays behind the committed pointer
    assert property (@(posedge clk) disable iff (!i_arst_n) i_data_rd |-> (used != '0))
        else $error("port_rx: read past committed data");

endmodule

// ==== verilog/interface_mux.sv ====
`timescale 1ns/1ps

module interface_mux (
    input  logic                                                clk,
    input  logic                                                i_arst_n,
    input  logic [switch_pkg::NUM_PORTS-1:0]                    i_desc_empty,
    input  switch_pkg::frame_desc_t [switch_pkg::NUM_PORTS-1:0] i_desc,
    input  switch_pkg::byte_t [switch_pkg::NUM_PORTS-1:0]       i_data,
    output logic [switch_pkg::NUM_PORTS-1:0]                    o_desc_rd,
    output logic [switch_pkg::NUM_PORTS-1:0]                    o_data_rd,
    input  logic [$bits(switch_pkg::buf_addr_t):0]              i_out_count,
    input  logic                                                i_out_desc_full,
    output logic                                                o_out_desc_wr,
    output switch_pkg::frame_desc_t                             o_out_desc,
    output logic                                                o_out_data_wr,
    output switch_pkg::byte_t                                   o_out_data
);

    import switch_pkg::*;

    mux_state_t  state;
    port_id_t    grant;
    port_id_t    pick;
    logic        any_req;
    logic        room_ok;
    frame_len_t  remaining;
    frame_desc_t head;

    // round robin, starting after the last granted port
    always_comb begin
        port_id_t cand;
        pick    = grant;
        any_req = 1'b0;
        for (int i = NUM_PORTS; i >= 1; i--) begin
            cand = grant + port_id_t'(i);
            if (!i_desc_empty[cand]) begin
                pick    = cand;
                any_req = 1'b1;
            end
        end
    end

    assign head    = i_desc[grant];
    // whole frame must fit before anything is popped
    assign room_ok = !i_out_desc_full
                     && ((int'(i_out_count) + int'(head.len)) <= BUF_DEPTH);

    always_comb begin
        o_desc_rd     = '0;
        o_data_rd     = '0;
        o_out_desc_wr = 1'b0;
        o_out_data_wr = 1'b0;
        if ((state == MUX_DESC) && room_ok) begin
            o_desc_rd[grant] = 1'b1;
            o_out_desc_wr    = 1'b1;
        end
        if (state == MUX_COPY) begin
            o_data_rd[grant] = 1'b1;
            o_out_data_wr    = 1'b1;
        end
    end

    assign o_out_desc = head;
    assign o_out_data = i_data[grant];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state     <= MUX_IDLE;
            grant     <= port_id_t'(NUM_PORTS - 1);
            remaining <= '0;
        end else begin
            case (state)
                MUX_IDLE: begin
                    if (any_req) begin
                        grant <= pick;
                        state <= MUX_DESC;
                    end
                end
                MUX_DESC: begin
                    if (room_ok) begin
                        remaining <= head.len;
                        state     <= MUX_COPY;
                    end
                end
                MUX_COPY: begin
                    remaining <= remaining - 1'b1;
                    // last byte of the frame
                    if (remaining == frame_len_t'(1)) begin
                        state <= MUX_IDLE;
                    end
                end
                default: begin
                    state <= MUX_IDLE;
                end
            endcase
        end
    end

    // a port is popped only while it holds a descriptor
    assert property (@(posedge clk) disable iff (!i_arst_n)
        $onehot0(o_desc_rd) && ((o_desc_rd & i_desc_empty) == '0))
        else $error("interface_mux: bad descriptor pop");

    // space reserved in MUX_DESC covers every copied byte
    assert property (@(posedge clk) disable iff (!i_arst_n)
        (|o_data_rd) |-> ((state == MUX_COPY) && (int'(i_out_count) < BUF_DEPTH)))
        else $error("interface_mux: copy outside a granted frame");

endmodule

// ==== verilog/switch_ingress_top.sv ====
`timescale 1ns/1ps

module switch_ingress_top (
    input  logic                                             clk,
    input  logic                                             i_arst_n,
    input  switch_pkg::gmii_rx_t [switch_pkg::NUM_PORTS-1:0] i_rx,
    input  logic                                             i_desc_rd,
    input  logic                                             i_data_rd,
    output logic                                             o_desc_empty,
    output switch_pkg::frame_desc_t                          o_desc,
    output switch_pkg::byte_t                                o_data
);

    import switch_pkg::*;

    logic        [NUM_PORTS-1:0] port_desc_empty;
    frame_desc_t [NUM_PORTS-1:0] port_desc;
    byte_t       [NUM_PORTS-1:0] port_data;
    logic        [NUM_PORTS-1:0] port_desc_rd;
    logic        [NUM_PORTS-1:0] port_data_rd;

    logic [$bits(buf_addr_t):0] out_count;
    logic                       out_desc_full;
    logic                       out_desc_wr;
    frame_desc_t                out_desc;
    logic                       out_data_wr;
    byte_t                      out_data;

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
        port_rx #(
            .PORT_ID (port_id_t'(g))
        ) u_port_rx (
            .clk          (clk),
            .i_arst_n     (i_arst_n),
            .i_rx         (i_rx[g]),
            .i_desc_rd    (port_desc_rd[g]),
            .i_data_rd    (port_data_rd[g]),
            .o_desc_empty (port_desc_empty[g]),
            .o_desc       (port_desc[g]),
            .o_data       (port_data[g])
        );
    end

    interface_mux u_interface_mux (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_desc_empty    (port_desc_empty),
        .i_desc          (port_desc),
        .i_data          (port_data),
        .o_desc_rd       (port_desc_rd),
        .o_data_rd       (port_data_rd),
        .i_out_count     (out_count),
        .i_out_desc_full (out_desc_full),
        .o_out_desc_wr   (out_desc_wr),
        .o_out_desc      (out_desc),
        .o_out_data_wr   (out_data_wr),
        .o_out_data      (out_data)
    );

    // shared output queue, descriptors
    sync_fifo #(
        .WIDTH ($bits(frame_desc_t)),
        .DEPTH (DESC_DEPTH)
    ) u_out_desc_fifo (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_wr     (out_desc_wr),
        .i_din    (out_desc),
        .i_rd     (i_desc_rd),
        .o_dout   (o_desc),
        .o_empty  (o_desc_empty),
        .o_full   (out_desc_full),
        .o_count  ()
    );

    // shared output queue, frame bytes
    sync_fifo #(
        .WIDTH ($bits(byte_t)),
        .DEPTH (BUF_DEPTH)
    ) u_out_data_fifo (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_wr     (out_data_wr),
        .i_din    (out_data),
        .i_rd     (i_data_rd),
        .o_dout   (o_data),
        .o_empty  (),
        .o_full   (),
        .o_count  (out_count)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) o_clk = ~o_clk;
        end
    end

endmodule

// ==== bench/tb_switch_ingress.sv ====
`timescale 1ns/1ps

module tb_switch_ingress;

    import switch_pkg::*;

    localparam int RESET_CYCLES  = 3;
    localparam int IFG_CYCLES    = 12;
    localparam int DRAIN_TIMEOUT = 20000;
    localparam int DESC_TIMEOUT  = 5000;
    localparam int EXP_FRAMES    = 64;
    localparam int EXP_BYTES     = 16384;

    logic                     clk;
    logic                     arst_n;
    gmii_rx_t                 rx_drv [NUM_PORTS];
    gmii_rx_t [NUM_PORTS-1:0] rx_bus;
    logic                     desc_rd;
    logic                     data_rd;
    logic                     desc_empty;
    frame_desc_t              desc;
    byte_t                    data;
    logic                     reader_en;

    int    seed = 67;
    // expected frames as one ring per source port
    byte_t exp_byte [NUM_PORTS][EXP_BYTES];
    int    exp_len [NUM_PORTS][EXP_FRAMES];
    int    byte_wr_idx [NUM_PORTS];
    int    byte_rd_idx [NUM_PORTS];
    int    frame_wr_idx [NUM_PORTS];
    int    frame_rd_idx [NUM_PORTS];

    tb_clock_gen #(.PERIOD_NS (8.0)) u_clock_gen (.o_clk (clk));

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_rx
        assign rx_bus[g] = rx_drv[g];
    end

    switch_ingress_top uut (
        .clk          (clk),
        .i_arst_n     (arst_n),
        .i_rx         (rx_bus),
        .i_desc_rd    (desc_rd),
        .i_data_rd    (data_rd),
        .o_desc_empty (desc_empty),
        .o_desc       (desc),
        .o_data       (data)
    );

    // validity rule for frames that fit the port buffer
    function automatic logic expect_accept(input int len, input logic had_err);
        return !had_err && (len >= MIN_FRAME_LEN) && (len <= MAX_FRAME_LEN);
    endfunction

    function automatic int rand_len(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'({$random(seed)} % span);
    endfunction

    function automatic int frames_pending();
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            n += frame_wr_idx[p] - frame_rd_idx[p];
        end
        return n;
    endfunction

    task automatic end_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            end_with_failure();
        end
    endtask

    // err_at below zero means a clean frame
    task automatic send_frame(input int port, input int len, input int err_at);
        gmii_rx_t beat;
        logic     keep;
        keep = expect_accept(len, err_at >= 0);
        for (int i = 0; i < len; i++) begin
            beat.dv   = 1'b1;
            beat.er   = (i == err_at);
            beat.data = byte_t'($random(seed));
            if (keep) begin
                exp_byte[port][byte_wr_idx[port] % EXP_BYTES] = beat.data;
                byte_wr_idx[port]++;
            end
            @(negedge clk);
            rx_drv[port] = beat;
        end
        @(negedge clk);
        rx_drv[port] = '0;
        if (keep) begin
            exp_len[port][frame_wr_idx[port] % EXP_FRAMES] = len;
            frame_wr_idx[port]++;
        end
        repeat (IFG_CYCLES - 1) @(negedge clk);
    endtask

    task automatic send_burst(input int port, input int count, input int max_len);
        for (int i = 0; i < count; i++) begin
            send_frame(port, rand_len(MIN_FRAME_LEN, max_len), -1);
        end
    endtask

    task automatic wait_drained(input int limit);
        int cycles;
        cycles = 0;
        while (frames_pending() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("timeout: %0d frames not delivered after %0d cycles",
                         frames_pending(), limit);
                end_with_failure();
            end
        end
    endtask

    task automatic wait_desc_ready(input int limit);
        int cycles;
        cycles = 0;
        while (desc_empty) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("timeout: no descriptor reached the output in %0d cycles", limit);
                end_with_failure();
            end
        end
    endtask

    // pops one descriptor and then its bytes at one per clock
    initial begin : reader
        frame_desc_t d;
        int          p;
        forever begin
            @(negedge clk);
            if (reader_en && !desc_empty) begin
                d       = desc;
                p       = int'(d.port);
                desc_rd = 1'b1;
                @(negedge clk);
                desc_rd = 1'b0;
                if (frame_rd_idx[p] == frame_wr_idx[p]) begin
                    $display("unexpected frame delivered from port %0d", p);
                    end_with_failure();
                end
                check("o_desc.len", 32'(d.len), exp_len[p][frame_rd_idx[p] % EXP_FRAMES]);
                for (int i = 0; i < int'(d.len); i++) begin
                    check("o_data", 32'(data),
                          32'(exp_byte[p][byte_rd_idx[p] % EXP_BYTES]));
                    byte_rd_idx[p]++;
                    data_rd = 1'b1;
                    @(negedge clk);
                end
                data_rd = 1'b0;
                frame_rd_idx[p]++;
            end
        end
    end

    initial begin : stimulus
        arst_n    = 1'b0;
        desc_rd   = 1'b0;
        data_rd   = 1'b0;
        reader_en = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            rx_drv[p]       = '0;
            byte_wr_idx[p]  = 0;
            byte_rd_idx[p]  = 0;
            frame_wr_idx[p] = 0;
            frame_rd_idx[p] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check("o_desc_empty", 32'(desc_empty), 32'd1);
        reader_en = 1'b1;

        for (int p = 0; p < NUM_PORTS; p++) begin
            send_frame(p, rand_len(MIN_FRAME_LEN, 200), -1);
            wait_drained(DRAIN_TIMEOUT);
        end

        // errored frame then a clean one
        send_frame(1, 100, 37);
        send_frame(1, 90, -1);
        wait_drained(DRAIN_TIMEOUT);

        send_frame(2, MIN_FRAME_LEN - 1, -1);
        send_frame(2, MAX_FRAME_LEN + 1, -1);
        send_frame(2, MIN_FRAME_LEN, -1);
        send_frame(2, MAX_FRAME_LEN, -1);
        wait_drained(DRAIN_TIMEOUT);

        fork
            send_burst(0, 3, 400);
            send_burst(1, 3, 400);
            send_burst(2, 3, 400);
            send_burst(3, 3, 400);
        join
        wait_drained(DRAIN_TIMEOUT);

        // output held while frames pile up in the queues
        reader_en = 1'b0;
        fork
            send_burst(0, 2, 180);
            send_burst(1, 2, 180);
            send_burst(2, 2, 180);
            send_burst(3, 2, 180);
        join
        wait_desc_ready(DESC_TIMEOUT);
        reader_en = 1'b1;
        wait_drained(DRAIN_TIMEOUT);
        check("o_desc_empty", 32'(desc_empty), 32'd1);

        if (frames_pending() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("expected frames still outstanding at end of test");
            end_with_failure();
        end
    end

endmodule

// ==== build.f ====
verilog/switch_pkg.sv
verilog/sync_fifo.sv
verilog/port_rx.sv
verilog/interface_mux.sv
verilog/switch_ingress_top.sv
bench/tb_clock_gen.sv
bench/tb_switch_ingress.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_switch_ingress
RTL_TOP   ?= switch_ingress_top
FILELIST  ?= build.f
RTL_SRCS  ?= $(shell grep '^verilog/' $(FILELIST))
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
